// ==== common/io_noc_pkg.sv ====
// Widths, port and opcode encodings and the packet format shared by the I/O router column
`default_nettype none

package io_noc_pkg;

  localparam int NUM_ROWS   = 4;
  localparam int X_W        = 4;
  localparam int Y_W        = 4;
  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  localparam int FIFO_DEPTH = 2;
  localparam int NUM_DIRS   = 5;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int DIR_W = $clog2(NUM_DIRS);

  // Sized buffer constants for pointer wrap and full detect
  localparam logic [PTR_W-1:0] PTR_LAST      = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FIFO_FULL_CNT = CNT_W'(FIFO_DEPTH);

  // Router port order, also the index of every link and grant array
  typedef enum logic [DIR_W-1:0] {
    P,
    W,
    E,
    N,
    S
  } dir_e;

  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_NOP   = 2'd2
  } op_e;

  typedef struct packed {
    logic [X_W-1:0]    dest_x;
    logic [Y_W-1:0]    dest_y;
    logic [Y_W-1:0]    src_y;
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } packet_s;

endpackage

`default_nettype wire

// ==== common/noc_link_if.sv ====
// One-way router link; the sender offers a packet with valid, the receiver takes it with ready
`default_nettype none

interface noc_link_if;

  logic                valid;
  logic                ready;
  io_noc_pkg::packet_s pkt;

  // Upstream side
  modport sender (
    output valid,
    output pkt,
    input  ready
  );

  // Downstream side, ready may rise without waiting for valid
  modport receiver (
    input  valid,
    input  pkt,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/io_router/io_router_input_fifo.sv ====
// Two-entry buffer on each router input, presenting its oldest packet to the route logic
`default_nettype none

module io_router_input_fifo (
  input  wire logic    clk_i,
  input  wire logic    reset_i,
  noc_link_if.receiver in_link,
  noc_link_if.sender   out_link
);

  io_noc_pkg::packet_s mem [io_noc_pkg::FIFO_DEPTH];

  logic [io_noc_pkg::PTR_W-1:0] wr_ptr_q;
  logic [io_noc_pkg::PTR_W-1:0] rd_ptr_q;
  logic [io_noc_pkg::CNT_W-1:0] count_q;
  logic                         full;
  logic                         empty;
  logic                         push;
  logic                         pop;

  assign full  = (count_q == io_noc_pkg::FIFO_FULL_CNT);
  assign empty = (count_q == '0);

  // Ready comes from the count only, never from the incoming valid
  assign in_link.ready  = !full;
  assign out_link.valid = !empty;
  assign out_link.pkt   = mem[rd_ptr_q];

  assign push = in_link.valid && !full;
  assign pop  = out_link.ready && !empty;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == io_noc_pkg::PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == io_noc_pkg::PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_link.pkt;
    end
  end

  // A packet refused by a full buffer waits at the input until there is room
  assert property (@(posedge clk_i) disable iff (reset_i)
    in_link.valid && !in_link.ready |=> in_link.valid && $stable(in_link.pkt));

  // Head holds until the crossbar takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    out_link.valid && !out_link.ready |=> out_link.valid && $stable(out_link.pkt));

endmodule

`default_nettype wire

// ==== design/io_router/io_router_rr_arbiter.sv ====
// Round-robin arbiter for one router output, holding its grant until the transfer completes
`default_nettype none

module io_router_rr_arbiter (
  input  wire logic                            clk_i,
  input  wire logic                            reset_i,
  input  wire logic [io_noc_pkg::NUM_DIRS-1:0] req_i,
  input  wire logic                            ack_i,
  output logic      [io_noc_pkg::NUM_DIRS-1:0] grant_o
);

  // One-hot of the last winner, zero after reset so P is searched first
  logic [io_noc_pkg::NUM_DIRS-1:0] last_q;
  logic [io_noc_pkg::NUM_DIRS-1:0] hold_q;
  logic [io_noc_pkg::NUM_DIRS-1:0] rr_pick;

  always_comb begin
    logic                            above;
    logic                            hit_hi;
    logic                            hit_lo;
    logic [io_noc_pkg::NUM_DIRS-1:0] pick_hi;
    logic [io_noc_pkg::NUM_DIRS-1:0] pick_lo;
    above   = 1'b0;
    hit_hi  = 1'b0;
    hit_lo  = 1'b0;
    pick_hi = '0;
    pick_lo = '0;
    // Lowest request above the last winner, else lowest request overall
    for (int i = 0; i < io_noc_pkg::NUM_DIRS; i++) begin
      if (req_i[i] && above && !hit_hi) begin
        pick_hi[i] = 1'b1;
        hit_hi     = 1'b1;
      end
      if (req_i[i] && !hit_lo) begin
        pick_lo[i] = 1'b1;
        hit_lo     = 1'b1;
      end
      above = above | last_q[i];
    end
    rr_pick = hit_hi ? pick_hi : pick_lo;
  end

  // A pending grant stays put so the output packet does not change
  assign grant_o = (|hold_q) ? hold_q : rr_pick;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q <= '0;
      hold_q <= '0;
    end else begin
      hold_q <= ack_i ? '0 : grant_o;
      if (ack_i) begin
        last_q <= grant_o;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(grant_o));

  // The router must keep requesting a held grant until it is consumed
  assert property (@(posedge clk_i) disable iff (reset_i)
    (|hold_q) |-> (|(hold_q & req_i)));

endmodule

`default_nettype wire

// ==== design/io_router/io_router.sv ====
// Five-port router of the column: input buffers, X-then-Y route compute, arbiters and crossbar
`default_nettype none

module io_router (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  noc_link_if.receiver                      in_links  [io_noc_pkg::NUM_DIRS],
  noc_link_if.sender                        out_links [io_noc_pkg::NUM_DIRS],
  input  wire logic [io_noc_pkg::X_W-1:0]   global_x_i,
  input  wire logic [io_noc_pkg::Y_W-1:0]   global_y_i
);

  noc_link_if head_links [io_noc_pkg::NUM_DIRS] ();

  logic                [io_noc_pkg::NUM_DIRS-1:0] head_valid;
  logic                [io_noc_pkg::NUM_DIRS-1:0] head_pop;
  io_noc_pkg::packet_s                            head_pkt [io_noc_pkg::NUM_DIRS];
  io_noc_pkg::dir_e                               head_dir [io_noc_pkg::NUM_DIRS];

  // Indexed [output][input]
  logic [io_noc_pkg::NUM_DIRS-1:0] req   [io_noc_pkg::NUM_DIRS];
  logic [io_noc_pkg::NUM_DIRS-1:0] grant [io_noc_pkg::NUM_DIRS];
  logic [io_noc_pkg::NUM_DIRS-1:0] xfer  [io_noc_pkg::NUM_DIRS];
  // Indexed [input][output]
  logic [io_noc_pkg::NUM_DIRS-1:0] pop_by [io_noc_pkg::NUM_DIRS];

  // X first, then Y; y grows toward the south
  function automatic io_noc_pkg::dir_e route_dir(
    input io_noc_pkg::packet_s          pkt,
    input logic [io_noc_pkg::X_W-1:0]   my_x,
    input logic [io_noc_pkg::Y_W-1:0]   my_y
  );
    if (pkt.dest_x < my_x) begin
      return io_noc_pkg::W;
    end
    if (pkt.dest_x > my_x) begin
      return io_noc_pkg::E;
    end
    if (pkt.dest_y < my_y) begin
      return io_noc_pkg::N;
    end
    if (pkt.dest_y > my_y) begin
      return io_noc_pkg::S;
    end
    return io_noc_pkg::P;
  endfunction

  for (genvar d = 0; d < io_noc_pkg::NUM_DIRS; d++) begin : g_in
    io_router_input_fifo fifo (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .in_link  (in_links[d]),
      .out_link (head_links[d])
    );

    assign head_valid[d]       = head_links[d].valid;
    assign head_pkt[d]         = head_links[d].pkt;
    assign head_links[d].ready = head_pop[d];
    assign head_dir[d]         = route_dir(head_pkt[d], global_x_i, global_y_i);

    for (genvar o = 0; o < io_noc_pkg::NUM_DIRS; o++) begin : g_col
      assign pop_by[d][o] = xfer[o][d];
    end
    assign head_pop[d] = |pop_by[d];

    // Each head routes to exactly one output, so only that output may pop it
    assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(pop_by[d]));
  end

  for (genvar o = 0; o < io_noc_pkg::NUM_DIRS; o++) begin : g_out
    logic                out_valid;
    logic                out_ready;
    io_noc_pkg::packet_s sel_pkt;

    for (genvar d = 0; d < io_noc_pkg::NUM_DIRS; d++) begin : g_req
      assign req[o][d] = head_valid[d] && (head_dir[d] == io_noc_pkg::dir_e'(o));
    end

    io_router_rr_arbiter arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (req[o]),
      .ack_i   (out_valid && out_ready),
      .grant_o (grant[o])
    );

    always_comb begin
      sel_pkt = head_pkt[0];
      for (int d = 0; d < io_noc_pkg::NUM_DIRS; d++) begin
        if (grant[o][d]) begin
          sel_pkt = head_pkt[d];
        end
      end
    end

    assign out_valid           = |grant[o];
    assign out_ready           = out_links[o].ready;
    assign out_links[o].valid  = out_valid;
    assign out_links[o].pkt    = sel_pkt;
    assign xfer[o]             = grant[o] & {io_noc_pkg::NUM_DIRS{out_ready}};
  end

endmodule

`default_nettype wire

// ==== design/io_router_column.sv ====
// Top of the I/O router column; chains the routers north to south and exposes plain link ports
`default_nettype none

module io_router_column (
  input  wire logic                                              clk_i,
  input  wire logic                                              reset_i,
  input  wire logic [io_noc_pkg::X_W-1:0]                        global_x_i,
  input  wire logic [io_noc_pkg::NUM_ROWS-1:0][io_noc_pkg::Y_W-1:0] global_y_i,

  // North edge of row 0
  input  wire logic                                              ver_n_valid_i,
  output wire logic                                              ver_n_ready_o,
  input  wire io_noc_pkg::packet_s                               ver_n_pkt_i,
  output wire logic                                              ver_n_valid_o,
  input  wire logic                                              ver_n_ready_i,
  output wire io_noc_pkg::packet_s                               ver_n_pkt_o,

  // South edge of the last row
  input  wire logic                                              ver_s_valid_i,
  output wire logic                                              ver_s_ready_o,
  input  wire io_noc_pkg::packet_s                               ver_s_pkt_i,
  output wire logic                                              ver_s_valid_o,
  input  wire logic                                              ver_s_ready_i,
  output wire io_noc_pkg::packet_s                               ver_s_pkt_o,

  input  wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_w_valid_i,
  output wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_w_ready_o,
  input  wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0]    hor_w_pkt_i,
  output wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_w_valid_o,
  input  wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_w_ready_i,
  output wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0]    hor_w_pkt_o,

  input  wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_e_valid_i,
  output wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_e_ready_o,
  input  wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0]    hor_e_pkt_i,
  output wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_e_valid_o,
  input  wire logic                [io_noc_pkg::NUM_ROWS-1:0]    hor_e_ready_i,
  output wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0]    hor_e_pkt_o,

  input  wire logic                [io_noc_pkg::NUM_ROWS-1:0]    proc_valid_i,
  output wire logic                [io_noc_pkg::NUM_ROWS-1:0]    proc_ready_o,
  input  wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0]    proc_pkt_i,
  output wire logic                [io_noc_pkg::NUM_ROWS-1:0]    proc_valid_o,
  input  wire logic                [io_noc_pkg::NUM_ROWS-1:0]    proc_ready_i,
  output wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0]    proc_pkt_o
);

  // Per row and port; li flows into a router, lo flows out of it
  wire logic [io_noc_pkg::NUM_ROWS-1:0][io_noc_pkg::NUM_DIRS-1:0] link_valid_li;
  wire logic [io_noc_pkg::NUM_ROWS-1:0][io_noc_pkg::NUM_DIRS-1:0] link_ready_lo;
  wire logic [io_noc_pkg::NUM_ROWS-1:0][io_noc_pkg::NUM_DIRS-1:0] link_valid_lo;
  wire logic [io_noc_pkg::NUM_ROWS-1:0][io_noc_pkg::NUM_DIRS-1:0] link_ready_li;
  wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0][io_noc_pkg::NUM_DIRS-1:0] link_pkt_li;
  wire io_noc_pkg::packet_s [io_noc_pkg::NUM_ROWS-1:0][io_noc_pkg::NUM_DIRS-1:0] link_pkt_lo;

  for (genvar i = 0; i < io_noc_pkg::NUM_ROWS; i++) begin : r
    noc_link_if in_links  [io_noc_pkg::NUM_DIRS] ();
    noc_link_if out_links [io_noc_pkg::NUM_DIRS] ();

    for (genvar d = 0; d < io_noc_pkg::NUM_DIRS; d++) begin : l
      assign in_links[d].valid   = link_valid_li[i][d];
      assign in_links[d].pkt     = link_pkt_li[i][d];
      assign link_ready_lo[i][d] = in_links[d].ready;
      assign link_valid_lo[i][d] = out_links[d].valid;
      assign link_pkt_lo[i][d]   = out_links[d].pkt;
      assign out_links[d].ready  = link_ready_li[i][d];
    end

    io_router io_rtr (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .in_links   (in_links),
      .out_links  (out_links),
      .global_x_i (global_x_i),
      .global_y_i (global_y_i[i])
    );

    assign link_valid_li[i][io_noc_pkg::W] = hor_w_valid_i[i];
    assign link_pkt_li[i][io_noc_pkg::W]   = hor_w_pkt_i[i];
    assign link_ready_li[i][io_noc_pkg::W] = hor_w_ready_i[i];
    assign hor_w_ready_o[i]                = link_ready_lo[i][io_noc_pkg::W];
    assign hor_w_valid_o[i]                = link_valid_lo[i][io_noc_pkg::W];
    assign hor_w_pkt_o[i]                  = link_pkt_lo[i][io_noc_pkg::W];

    assign link_valid_li[i][io_noc_pkg::E] = hor_e_valid_i[i];
    assign link_pkt_li[i][io_noc_pkg::E]   = hor_e_pkt_i[i];
    assign link_ready_li[i][io_noc_pkg::E] = hor_e_ready_i[i];
    assign hor_e_ready_o[i]                = link_ready_lo[i][io_noc_pkg::E];
    assign hor_e_valid_o[i]                = link_valid_lo[i][io_noc_pkg::E];
    assign hor_e_pkt_o[i]                  = link_pkt_lo[i][io_noc_pkg::E];

    assign link_valid_li[i][io_noc_pkg::P] = proc_valid_i[i];
    assign link_pkt_li[i][io_noc_pkg::P]   = proc_pkt_i[i];
    assign link_ready_li[i][io_noc_pkg::P] = proc_ready_i[i];
    assign proc_ready_o[i]                 = link_ready_lo[i][io_noc_pkg::P];
    assign proc_valid_o[i]                 = link_valid_lo[i][io_noc_pkg::P];
    assign proc_pkt_o[i]                   = link_pkt_lo[i][io_noc_pkg::P];

    // South of row i meets north of row i+1
    if (i != io_noc_pkg::NUM_ROWS - 1) begin : g_chain
      assign link_valid_li[i+1][io_noc_pkg::N] = link_valid_lo[i][io_noc_pkg::S];
      assign link_pkt_li[i+1][io_noc_pkg::N]   = link_pkt_lo[i][io_noc_pkg::S];
      assign link_ready_li[i][io_noc_pkg::S]   = link_ready_lo[i+1][io_noc_pkg::N];
      assign link_valid_li[i][io_noc_pkg::S]   = link_valid_lo[i+1][io_noc_pkg::N];
      assign link_pkt_li[i][io_noc_pkg::S]     = link_pkt_lo[i+1][io_noc_pkg::N];
      assign link_ready_li[i+1][io_noc_pkg::N] = link_ready_lo[i][io_noc_pkg::S];
    end
  end

  assign link_valid_li[0][io_noc_pkg::N] = ver_n_valid_i;
  assign link_pkt_li[0][io_noc_pkg::N]   = ver_n_pkt_i;
  assign link_ready_li[0][io_noc_pkg::N] = ver_n_ready_i;
  assign ver_n_ready_o                   = link_ready_lo[0][io_noc_pkg::N];
  assign ver_n_valid_o                   = link_valid_lo[0][io_noc_pkg::N];
  assign ver_n_pkt_o                     = link_pkt_lo[0][io_noc_pkg::N];

  assign link_valid_li[io_noc_pkg::NUM_ROWS-1][io_noc_pkg::S] = ver_s_valid_i;
  assign link_pkt_li[io_noc_pkg::NUM_ROWS-1][io_noc_pkg::S]   = ver_s_pkt_i;
  assign link_ready_li[io_noc_pkg::NUM_ROWS-1][io_noc_pkg::S] = ver_s_ready_i;
  assign ver_s_ready_o = link_ready_lo[io_noc_pkg::NUM_ROWS-1][io_noc_pkg::S];
  assign ver_s_valid_o = link_valid_lo[io_noc_pkg::NUM_ROWS-1][io_noc_pkg::S];
  assign ver_s_pkt_o   = link_pkt_lo[io_noc_pkg::NUM_ROWS-1][io_noc_pkg::S];

endmodule

`default_nettype wire

// ==== dv/io_router_checker.sv ====
// Scoreboard for the router column testbench; holds expected packets per exit and checks outputs
`default_nettype none

module io_router_checker #(
  parameter int NUM_PORTS = 14
) (
  input wire logic                                 clk_i,
  input wire logic                                 reset_i,
  input wire logic                [NUM_PORTS-1:0]  in_ready_i,
  input wire logic                [NUM_PORTS-1:0]  out_valid_i,
  input wire logic                [NUM_PORTS-1:0]  out_ready_i,
  input wire io_noc_pkg::packet_s [NUM_PORTS-1:0]  out_pkt_i
);

  io_noc_pkg::packet_s                 exp_q [NUM_PORTS][$];
  logic                [NUM_PORTS-1:0] held_q;
  io_noc_pkg::packet_s [NUM_PORTS-1:0] last_pkt_q;

  int pending      = 0;
  int errors       = 0;
  int test_errs    = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  // Exit order is proc, hor_w, hor_e per row, then ver_n and ver_s
  function automatic string port_name(input int e);
    if (e < 4) return $sformatf("proc_pkt_o[%0d]", e);
    if (e < 8) return $sformatf("hor_w_pkt_o[%0d]", e - 4);
    if (e < 12) return $sformatf("hor_e_pkt_o[%0d]", e - 8);
    if (e == 12) return "ver_n_pkt_o";
    return "ver_s_pkt_o";
  endfunction

  task automatic note_fail();
    errors++;
    test_errs++;
  endtask

  task automatic expect_pkt(input int e, input io_noc_pkg::packet_s pkt);
    exp_q[e].push_back(pkt);
    pending++;
  endtask

  // Oldest entry with the same source tag must be the one that arrives
  task automatic match_output(input int e);
    int                  idx;
    io_noc_pkg::packet_s act;
    act = out_pkt_i[e];
    idx = -1;
    for (int i = exp_q[e].size() - 1; i >= 0; i--) begin
      if (exp_q[e][i].addr[15:12] == act.addr[15:12]) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      note_fail();
      $display("[FAIL] t=%0t %s: nothing from source %0d expected here, actual %h",
               $time, port_name(e), act.addr[15:12], act);
    end else begin
      if (exp_q[e][idx] != act) begin
        note_fail();
        $display("[FAIL] t=%0t %s: expected %h actual %h",
                 $time, port_name(e), exp_q[e][idx], act);
      end
      exp_q[e].delete(idx);
      pending--;
    end
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      for (int e = 0; e < NUM_PORTS; e++) begin
        if (held_q[e] && (!out_valid_i[e] || out_pkt_i[e] != last_pkt_q[e])) begin
          note_fail();
          $display("[FAIL] t=%0t %s changed while stalled: expected %h actual %h",
                   $time, port_name(e), last_pkt_q[e], out_pkt_i[e]);
        end
        if (out_valid_i[e] && out_ready_i[e]) begin
          match_output(e);
        end
      end
    end
    held_q     <= reset_i ? '0 : (out_valid_i & ~out_ready_i);
    last_pkt_q <= out_pkt_i;
  end

  task automatic check_idle();
    if (out_valid_i != '0) begin
      note_fail();
      $display("[FAIL] t=%0t out_valid: expected %h actual %h", $time, 14'h0, out_valid_i);
    end
    if (in_ready_i != '1) begin
      note_fail();
      $display("[FAIL] t=%0t in_ready: expected %h actual %h", $time, 14'h3fff, in_ready_i);
    end
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %0s: ok", name);
    end else begin
      tests_failed++;
      $display("test %0s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic report_counts();
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
  endtask

endmodule

`default_nettype wire

// ==== dv/tb_io_router_column.sv ====
// Testbench for the router column; random packets from every edge port, checked by the scoreboard
`default_nettype none

module tb_io_router_column;

  localparam logic [31:0] SEED = 32'hc500bb51;
  localparam int NUM_EXITS = 14;
  localparam int EX_W = 4;
  localparam int EX_E = 8;
  localparam int EX_N = 12;
  localparam int EX_S = 13;
  localparam int RAND_PKTS = 300;
  localparam int TOTAL_PKTS = NUM_EXITS * 4 + NUM_EXITS * 2 * 2 + RAND_PKTS;
  localparam logic [3:0] COL_X = 4'd5;
  localparam logic [3:0] Y_FIRST = 4'd2;
  localparam logic [3:0] Y_LAST = 4'd5;

  logic                                clk;
  logic                                reset;
  logic                                random_sink;
  logic [31:0]                         rng;
  logic [31:0]                         sink_rng;
  logic                [NUM_EXITS-1:0] in_valid;
  io_noc_pkg::packet_s [NUM_EXITS-1:0] in_pkt;
  logic                [NUM_EXITS-1:0] out_ready;
  wire logic           [NUM_EXITS-1:0] in_ready;
  wire logic           [NUM_EXITS-1:0] out_valid;
  wire io_noc_pkg::packet_s [NUM_EXITS-1:0] out_pkt;
  io_noc_pkg::packet_s src_q [NUM_EXITS][$];

  io_router_column DUT (
    .clk_i         (clk),
    .reset_i       (reset),
    .global_x_i    (COL_X),
    .global_y_i    ({4'd5, 4'd4, 4'd3, 4'd2}),
    .ver_n_valid_i (in_valid[EX_N]),
    .ver_n_ready_o (in_ready[EX_N]),
    .ver_n_pkt_i   (in_pkt[EX_N]),
    .ver_n_valid_o (out_valid[EX_N]),
    .ver_n_ready_i (out_ready[EX_N]),
    .ver_n_pkt_o   (out_pkt[EX_N]),
    .ver_s_valid_i (in_valid[EX_S]),
    .ver_s_ready_o (in_ready[EX_S]),
    .ver_s_pkt_i   (in_pkt[EX_S]),
    .ver_s_valid_o (out_valid[EX_S]),
    .ver_s_ready_i (out_ready[EX_S]),
    .ver_s_pkt_o   (out_pkt[EX_S]),
    .hor_w_valid_i (in_valid[7:4]),
    .hor_w_ready_o (in_ready[7:4]),
    .hor_w_pkt_i   (in_pkt[7:4]),
    .hor_w_valid_o (out_valid[7:4]),
    .hor_w_ready_i (out_ready[7:4]),
    .hor_w_pkt_o   (out_pkt[7:4]),
    .hor_e_valid_i (in_valid[11:8]),
    .hor_e_ready_o (in_ready[11:8]),
    .hor_e_pkt_i   (in_pkt[11:8]),
    .hor_e_valid_o (out_valid[11:8]),
    .hor_e_ready_i (out_ready[11:8]),
    .hor_e_pkt_o   (out_pkt[11:8]),
    .proc_valid_i  (in_valid[3:0]),
    .proc_ready_o  (in_ready[3:0]),
    .proc_pkt_i    (in_pkt[3:0]),
    .proc_valid_o  (out_valid[3:0]),
    .proc_ready_i  (out_ready[3:0]),
    .proc_pkt_o    (out_pkt[3:0])
  );

  io_router_checker #(.NUM_PORTS(NUM_EXITS)) scoreboard (
    .clk_i       (clk),
    .reset_i     (reset),
    .in_ready_i  (in_ready),
    .out_valid_i (out_valid),
    .out_ready_i (out_ready),
    .out_pkt_i   (out_pkt)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Edge ports ver_n and ver_s belong to the first and last row
  function automatic int src_row(input int s);
    if (s == EX_N) return 0;
    if (s == EX_S) return io_noc_pkg::NUM_ROWS - 1;
    return s % io_noc_pkg::NUM_ROWS;
  endfunction

  // X first, then Y, with row 0 at y 2
  function automatic int expected_port(input int row, input io_noc_pkg::packet_s pkt);
    if (pkt.dest_x < COL_X) return EX_W + row;
    if (pkt.dest_x > COL_X) return EX_E + row;
    if (pkt.dest_y < Y_FIRST) return EX_N;
    if (pkt.dest_y > Y_LAST) return EX_S;
    return int'(pkt.dest_y - Y_FIRST);
  endfunction

  // Source index rides in the top address bits so the scoreboard can check order
  task automatic queue_pkt(input int s, input logic [3:0] dx, input logic [3:0] dy);
    io_noc_pkg::packet_s pkt;
    rng = xorshift(rng);
    pkt.dest_x = dx;
    pkt.dest_y = dy;
    pkt.src_y  = 4'(src_row(s)) + Y_FIRST;
    pkt.op     = io_noc_pkg::op_e'((rng[1:0] == 2'd3) ? 2'd2 : rng[1:0]);
    pkt.addr   = {4'(s), rng[13:2]};
    rng = xorshift(rng);
    pkt.data   = rng;
    src_q[s].push_back(pkt);
  endtask

  task automatic drain();
    int queued;
    do begin
      @(posedge clk);
      queued = 0;
      for (int s = 0; s < NUM_EXITS; s++) begin
        queued += src_q[s].size();
      end
    end while (queued != 0 || in_valid != '0 || scoreboard.pending != 0);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Source side: record each accepted packet, then offer the next one
  always @(posedge clk) begin
    if (!reset) begin
      for (int s = 0; s < NUM_EXITS; s++) begin
        if (in_valid[s] && in_ready[s]) begin
          scoreboard.expect_pkt(expected_port(src_row(s), src_q[s][0]), src_q[s][0]);
          void'(src_q[s].pop_front());
        end
        if (src_q[s].size() > 0) begin
          in_valid[s] <= 1'b1;
          in_pkt[s]   <= src_q[s][0];
        end else begin
          in_valid[s] <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    sink_rng = xorshift(sink_rng);
    out_ready <= random_sink ? sink_rng[NUM_EXITS-1:0] : '1;
  end

  initial begin
    repeat (TOTAL_PKTS * 40 + 1000) @(posedge clk);
    $display("watchdog: run stopped after %0d cycles with %0d packets still pending",
             TOTAL_PKTS * 40 + 1000, scoreboard.pending);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    rng         = SEED;
    sink_rng    = ~SEED;
    random_sink <= 1'b0;
    reset       <= 1'b1;
    in_valid    <= '0;
    in_pkt      <= '0;
    out_ready   <= '1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    scoreboard.check_idle();
    scoreboard.end_test("reset_idle");

    for (int s = 0; s < NUM_EXITS; s++) begin
      for (int k = 0; k < io_noc_pkg::NUM_ROWS; k++) begin
        queue_pkt(s, COL_X, Y_FIRST + 4'(k));
      end
    end
    drain();
    scoreboard.end_test("local_delivery");

    for (int s = 0; s < NUM_EXITS; s++) begin
      rng = xorshift(rng);
      queue_pkt(s, {2'b0, rng[1:0]}, rng[7:4]);
      queue_pkt(s, 4'd6 + {2'b0, rng[9:8]}, rng[15:12]);
    end
    drain();
    scoreboard.end_test("x_first");

    for (int s = 0; s < NUM_EXITS; s++) begin
      rng = xorshift(rng);
      queue_pkt(s, COL_X, {3'b0, rng[0]});
      queue_pkt(s, COL_X, 4'd6 + {1'b0, rng[6:4]});
    end
    drain();
    scoreboard.end_test("through_traffic");

    random_sink <= 1'b1;
    for (int i = 0; i < RAND_PKTS; i++) begin
      rng = xorshift(rng);
      queue_pkt(int'(rng[7:0]) % NUM_EXITS, rng[8] ? COL_X : rng[15:12], rng[19:16]);
    end
    drain();
    random_sink <= 1'b0;
    scoreboard.end_test("contention");

    scoreboard.report_counts();
    if (scoreboard.errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/io_noc_pkg.sv
common/noc_link_if.sv
design/io_router/io_router_input_fifo.sv
design/io_router/io_router_rr_arbiter.sv
design/io_router/io_router.sv
design/io_router_column.sv
dv/io_router_checker.sv
dv/tb_io_router_column.sv

// ==== run.sh ====
#!/bin/sh
# Builds the router column testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_io_router_column -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "^TEST PASS$" sim.log
